// File: common/mipsPkg.sv
package mipsPkg;

    localparam int dataW    = 32;
    localparam int regAddrW = 5;

    typedef logic [dataW-1:0]    word_t;
    typedef logic [regAddrW-1:0] regAddr_t;

    ////////////////////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////////////////////

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct codes under opSpecial
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    ////////////////////////////////////////////////////////////////////////////
    // decoded control
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOp_e;

    // link is pc+8, past the delay slot
    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbLink
    } wbSel_e;

    typedef struct packed {
        aluOp_e   aluOp;
        logic     useImm;
        logic     immSigned;
        logic     shiftByImm;
        logic     regWrite;
        regAddr_t dest;
        logic     memRead;
        logic     memWrite;
        wbSel_e   wbSel;
        logic     isBranch;
        logic     branchOnNe;
        logic     isJump;
        logic     jumpReg;
    } ctrl_t;

endpackage

// File: common/memReqIf.sv
`timescale 1ns/100ps

interface memReqIf;
    import mipsPkg::*;

    logic  start;
    logic  wr;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  done;

    // sequencer side
    modport client (output start, wr, addr, wdata, input rdata, done);

    // bus master side
    modport master (input start, wr, addr, wdata, output rdata, done);

endinterface

// File: core/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  mipsPkg::word_t instr,
    output mipsPkg::ctrl_t ctrl
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // all-inactive default, so unknown codes fall through as a nop
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        ctrl.wbSel = wbAlu;
        case (opcode)
            opSpecial: begin
                ctrl.regWrite = 1'b1;
                ctrl.dest     = instr[15:11];
                case (funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnNor:  ctrl.aluOp = aluNor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSltu: ctrl.aluOp = aluSltu;
                    fnSll, fnSrl, fnSra: begin
                        ctrl.shiftByImm = 1'b1;
                        ctrl.aluOp = (funct == fnSll) ? aluSll :
                                     (funct == fnSrl) ? aluSrl : aluSra;
                    end
                    fnJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.isJump   = 1'b1;
                        ctrl.jumpReg  = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end
            // immediate group, result goes to rt
            opAddiu, opSlti, opAndi, opOri, opXori, opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.dest      = instr[20:16];
                ctrl.useImm    = 1'b1;
                ctrl.immSigned = (opcode == opAddiu) || (opcode == opSlti);
                case (opcode)
                    opSlti:  ctrl.aluOp = aluSlt;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opLw, opSw: begin
                ctrl.useImm    = 1'b1;
                ctrl.immSigned = 1'b1;
                ctrl.memRead   = (opcode == opLw);
                ctrl.memWrite  = (opcode == opSw);
                ctrl.regWrite  = (opcode == opLw);
                ctrl.dest      = instr[20:16];
                ctrl.wbSel     = wbMem;
            end
            opBeq, opBne: begin
                ctrl.isBranch   = 1'b1;
                ctrl.branchOnNe = (opcode == opBne);
            end
            opJ, opJal: begin
                ctrl.isJump   = 1'b1;
                ctrl.regWrite = (opcode == opJal);
                ctrl.dest     = 5'd31;
                ctrl.wbSel    = wbLink;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: core/alu.sv
`timescale 1ns/100ps

module alu (
    input  mipsPkg::aluOp_e op,
    input  mipsPkg::word_t  a,
    input  mipsPkg::word_t  b,
    input  logic [4:0]      shamt,
    output mipsPkg::word_t  result
);
    import mipsPkg::*;

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluNor:  result = ~(a | b);
            aluSlt:  result = word_t'($signed(a) < $signed(b));
            aluSltu: result = word_t'(a < b);
            // shifts always act on b (rt)
            aluSll:  result = b << shamt;
            aluSrl:  result = b >> shamt;
            aluSra:  result = $signed(b) >>> shamt;
            aluLui:  result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

// File: core/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic              clock,
    input  logic              rstN,
    input  mipsPkg::regAddr_t raddrA,
    input  mipsPkg::regAddr_t raddrB,
    output mipsPkg::word_t    rdataA,
    output mipsPkg::word_t    rdataB,
    input  logic              we,
    input  mipsPkg::regAddr_t waddr,
    input  mipsPkg::word_t    wdata
);
    import mipsPkg::*;

    word_t regs [32];

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // $0 is hardwired
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

// File: core/instrSequencer.sv
`timescale 1ns/100ps

module instrSequencer #(
    parameter mipsPkg::word_t resetPc = 32'hbfc00000
) (
    input  logic              clock,
    input  logic              rstN,
    memReqIf.client           fetch,
    memReqIf.client           data,
    output mipsPkg::regAddr_t raddrA,
    output mipsPkg::regAddr_t raddrB,
    input  mipsPkg::word_t    rdataA,
    input  mipsPkg::word_t    rdataB,
    output logic              regWe,
    output mipsPkg::regAddr_t regWaddr,
    output mipsPkg::word_t    regWdata,
    output mipsPkg::word_t    instr,
    input  mipsPkg::ctrl_t    ctrl,
    output mipsPkg::aluOp_e   aluOp,
    output mipsPkg::word_t    aluA,
    output mipsPkg::word_t    aluB,
    output logic [4:0]        aluShamt,
    input  mipsPkg::word_t    aluResult,
    output mipsPkg::word_t    debugWbPc,
    output logic [3:0]        debugWbRfWen,
    output mipsPkg::regAddr_t debugWbRfWnum,
    output mipsPkg::word_t    debugWbRfWdata
);
    import mipsPkg::*;

    typedef enum logic [2:0] {
        stFetch,
        stWaitInstr,
        stExecute,
        stMemAccess,
        stWriteback
    } state_e;

    state_e state;
    word_t  pc;
    word_t  nextPc;
    logic   redirect;
    word_t  targetQ;
    word_t  wbData;

    word_t  pcPlus4;
    word_t  imm;
    word_t  target;
    logic   taken;
    logic   isMem;

    ////////////////////////////////////////////////////////////////////////////
    // operands and branch resolution
    ////////////////////////////////////////////////////////////////////////////

    // fetch master holds the word until the next fetch completes
    assign instr   = fetch.rdata;
    assign raddrA  = instr[25:21];
    assign raddrB  = instr[20:16];
    assign pcPlus4 = pc + 32'd4;
    assign imm     = ctrl.immSigned ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};

    assign aluOp    = ctrl.aluOp;
    assign aluA     = rdataA;
    assign aluB     = ctrl.useImm ? imm : rdataB;
    assign aluShamt = ctrl.shiftByImm ? instr[10:6] : rdataA[4:0];

    always_comb begin
        taken  = 1'b0;
        target = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
        if (ctrl.isJump) begin
            taken  = 1'b1;
            target = ctrl.jumpReg ? rdataA : {pcPlus4[31:28], instr[25:0], 2'b00};
        end else if (ctrl.isBranch) begin
            taken = (rdataA == rdataB) ^ ctrl.branchOnNe;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus requests
    ////////////////////////////////////////////////////////////////////////////

    assign isMem = ctrl.memRead || ctrl.memWrite;

    assign fetch.start = (state == stFetch);
    assign fetch.wr    = 1'b0;
    assign fetch.addr  = pc;
    assign fetch.wdata = '0;

    // operands stay put until write-back, so addr and wdata are stable
    assign data.start = (state == stExecute) && isMem;
    assign data.wr    = ctrl.memWrite;
    assign data.addr  = aluResult;
    assign data.wdata = rdataB;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state    <= stFetch;
            pc       <= resetPc;
            nextPc   <= resetPc + 32'd4;
            redirect <= 1'b0;
        end else begin
            case (state)
                stFetch: state <= stWaitInstr;
                stWaitInstr: begin
                    if (fetch.done) begin
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    redirect <= taken;
                    state    <= isMem ? stMemAccess : stWriteback;
                end
                stMemAccess: begin
                    if (data.done) begin
                        state <= stWriteback;
                    end
                end
                stWriteback: begin
                    // delay slot runs next, the target after it
                    pc     <= nextPc;
                    nextPc <= redirect ? targetQ : nextPc + 32'd4;
                    state  <= stFetch;
                end
                default: state <= stFetch;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == stExecute) begin
            targetQ <= target;
            wbData  <= (ctrl.wbSel == wbLink) ? pc + 32'd8 : aluResult;
        end else if (state == stMemAccess && data.done && ctrl.wbSel == wbMem) begin
            wbData <= data.rdata;
        end
    end

    // write-back and trace
    assign regWe    = (state == stWriteback) && ctrl.regWrite;
    assign regWaddr = ctrl.dest;
    assign regWdata = wbData;

    assign debugWbPc      = pc;
    assign debugWbRfWen   = (regWe && ctrl.dest != '0) ? 4'hf : 4'h0;
    assign debugWbRfWnum  = ctrl.dest;
    assign debugWbRfWdata = wbData;

endmodule

// File: rtl/sramMaster.sv
`timescale 1ns/100ps

module sramMaster (
    input  logic           clock,
    input  logic           rstN,
    memReqIf.master        client,
    output logic           req,
    output logic           wr,
    output logic [1:0]     size,
    output mipsPkg::word_t addr,
    output mipsPkg::word_t wdata,
    input  logic           addrOk,
    input  logic           dataOk,
    input  mipsPkg::word_t rdata
);

    typedef enum logic [1:0] {
        stIdle,
        stRequest,
        stWaitData
    } state_e;

    state_e state;

    // client keeps these stable until done
    assign req   = (state == stRequest);
    assign wr    = client.wr;
    assign addr  = client.addr;
    assign wdata = client.wdata;
    // word accesses only
    assign size  = 2'd2;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state       <= stIdle;
            client.done <= 1'b0;
        end else begin
            client.done <= 1'b0;
            case (state)
                stIdle: begin
                    if (client.start) begin
                        state <= stRequest;
                    end
                end
                stRequest: begin
                    if (addrOk) begin
                        state <= stWaitData;
                    end
                end
                stWaitData: begin
                    if (dataOk) begin
                        state       <= stIdle;
                        client.done <= 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // read word held until the next access returns
    always_ff @(posedge clock) begin
        if (state == stWaitData && dataOk) begin
            client.rdata <= rdata;
        end
    end

endmodule

// File: rtl/mipsCore.sv
`timescale 1ns/100ps

module mipsCore #(
    parameter mipsPkg::word_t resetPc = 32'hbfc00000
) (
    input  logic              clock,
    input  logic              rstN,

    output logic              instSramReq,
    output logic              instSramWr,
    output logic [1:0]        instSramSize,
    output mipsPkg::word_t    instSramAddr,
    output mipsPkg::word_t    instSramWdata,
    input  logic              instSramAddrOk,
    input  logic              instSramDataOk,
    input  mipsPkg::word_t    instSramRdata,

    output logic              dataSramReq,
    output logic              dataSramWr,
    output logic [1:0]        dataSramSize,
    output mipsPkg::word_t    dataSramAddr,
    output mipsPkg::word_t    dataSramWdata,
    input  logic              dataSramAddrOk,
    input  logic              dataSramDataOk,
    input  mipsPkg::word_t    dataSramRdata,

    output mipsPkg::word_t    debugWbPc,
    output logic [3:0]        debugWbRfWen,
    output mipsPkg::regAddr_t debugWbRfWnum,
    output mipsPkg::word_t    debugWbRfWdata
);
    import mipsPkg::*;

    memReqIf fetchReq ();
    memReqIf dataReq ();

    word_t    instr;
    ctrl_t    ctrl;
    aluOp_e   aluOp;
    word_t    aluA;
    word_t    aluB;
    logic [4:0] aluShamt;
    word_t    aluResult;
    regAddr_t raddrA;
    regAddr_t raddrB;
    word_t    rdataA;
    word_t    rdataB;
    logic     regWe;
    regAddr_t regWaddr;
    word_t    regWdata;

    ////////////////////////////////////////////////////////////////////////////
    // datapath and control
    ////////////////////////////////////////////////////////////////////////////

    instrSequencer #(.resetPc(resetPc)) uSequencer (
        .clock, .rstN,
        .fetch(fetchReq), .data(dataReq),
        .raddrA, .raddrB, .rdataA, .rdataB,
        .regWe, .regWaddr, .regWdata,
        .instr, .ctrl,
        .aluOp, .aluA, .aluB, .aluShamt, .aluResult,
        .debugWbPc, .debugWbRfWen, .debugWbRfWnum, .debugWbRfWdata
    );

    controlUnit uControl (.instr, .ctrl);

    alu uAlu (.op(aluOp), .a(aluA), .b(aluB), .shamt(aluShamt), .result(aluResult));

    regFile uRegFile (
        .clock, .rstN,
        .raddrA, .raddrB, .rdataA, .rdataB,
        .we(regWe), .waddr(regWaddr), .wdata(regWdata)
    );

    // instruction and data bus masters
    sramMaster uInstPort (
        .clock, .rstN, .client(fetchReq),
        .req(instSramReq), .wr(instSramWr), .size(instSramSize),
        .addr(instSramAddr), .wdata(instSramWdata),
        .addrOk(instSramAddrOk), .dataOk(instSramDataOk), .rdata(instSramRdata)
    );

    sramMaster uDataPort (
        .clock, .rstN, .client(dataReq),
        .req(dataSramReq), .wr(dataSramWr), .size(dataSramSize),
        .addr(dataSramAddr), .wdata(dataSramWdata),
        .addrOk(dataSramAddrOk), .dataOk(dataSramDataOk), .rdata(dataSramRdata)
    );

endmodule

// File: test/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter int period = 100
) (
    output logic clock
);

    // free-running, starts low
    initial begin
        clock = 1'b0;
        forever begin
            #(period / 2) clock = ~clock;
        end
    end

endmodule

// File: test/mipsCoreSva.sv
`timescale 1ns/100ps

module mipsCoreSva (
    input logic              clock,
    input logic              rstN,
    input logic              instSramReq,
    input logic              instSramAddrOk,
    input logic [1:0]        instSramSize,
    input mipsPkg::word_t    instSramAddr,
    input logic              dataSramReq,
    input logic              dataSramAddrOk,
    input logic [1:0]        dataSramSize,
    input mipsPkg::word_t    dataSramAddr,
    input logic [3:0]        debugWbRfWen,
    input mipsPkg::regAddr_t debugWbRfWnum
);

    // req held with a stable address until accepted
    instReqHeld: assert property (@(posedge clock) disable iff (!rstN)
        instSramReq && !instSramAddrOk |=> instSramReq && $stable(instSramAddr))
        else $error("instruction bus dropped req or moved addr before addrOk");
    dataReqHeld: assert property (@(posedge clock) disable iff (!rstN)
        dataSramReq && !dataSramAddrOk |=> dataSramReq && $stable(dataSramAddr))
        else $error("data bus dropped req or moved addr before addrOk");

    // word accesses only
    instWordSize: assert property (@(posedge clock) disable iff (!rstN)
        instSramReq |-> instSramSize == 2'd2)
        else $error("instruction bus size is not word");
    dataWordSize: assert property (@(posedge clock) disable iff (!rstN)
        dataSramReq |-> dataSramSize == 2'd2)
        else $error("data bus size is not word");

    traceNonZero: assert property (@(posedge clock) disable iff (!rstN)
        debugWbRfWen != 4'h0 |-> debugWbRfWnum != '0)
        else $error("write-back traced for register 0");

endmodule

bind mipsCore mipsCoreSva uSva (.*);

// File: test/tbMipsCore.sv
`timescale 1ns/100ps

module tbMipsCore;
    import mipsPkg::*;

    localparam int waitLimit  = 400;
    localparam int quietCycles = 60;

    logic       clock;
    logic       rstN;

    // index 0 is the instruction bus, 1 the data bus
    logic       busReq    [2];
    logic       busWr     [2];
    logic [1:0] busSize   [2];
    word_t      busAddr   [2];
    word_t      busWdata  [2];
    logic       busAddrOk [2];
    logic       busDataOk [2];
    word_t      busRdata  [2];

    word_t      debugWbPc;
    logic [3:0] debugWbRfWen;
    regAddr_t   debugWbRfWnum;
    word_t      debugWbRfWdata;

    word_t      mem [word_t];
    int         wTest [$];
    word_t      wPc [$];
    word_t      wReg [$];
    word_t      wData [$];
    word_t      mAddr [$];
    word_t      mData [$];

    int         errors;
    int         testErrors;
    int         testsPassed;
    int         testsFailed;
    int         traceCount;

    clockGen #(.period(100)) uClock (.clock);

    mipsCore #(.resetPc(32'h0)) u_mipsCore (
        .clock, .rstN,
        .instSramReq(busReq[0]), .instSramWr(busWr[0]), .instSramSize(busSize[0]),
        .instSramAddr(busAddr[0]), .instSramWdata(busWdata[0]),
        .instSramAddrOk(busAddrOk[0]), .instSramDataOk(busDataOk[0]),
        .instSramRdata(busRdata[0]),
        .dataSramReq(busReq[1]), .dataSramWr(busWr[1]), .dataSramSize(busSize[1]),
        .dataSramAddr(busAddr[1]), .dataSramWdata(busWdata[1]),
        .dataSramAddrOk(busAddrOk[1]), .dataSramDataOk(busDataOk[1]),
        .dataSramRdata(busRdata[1]),
        .debugWbPc, .debugWbRfWen, .debugWbRfWnum, .debugWbRfWdata
    );

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t readWord(input word_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a5a5a;
    endfunction

    // one access at a time, 0 to 3 idle cycles before each ok
    task automatic serveBus(input int b);
        int    gap;
        word_t a;
        forever begin
            @(posedge clock);
            #1;
            if (rstN && busReq[b]) begin
                a   = busAddr[b];
                if (b == 0 && busWr[b] !== 1'b0) begin
                    $display("[FAIL] instSramWr: expected 0, got %h", busWr[b]);
                    errors++;
                end
                gap = int'($urandom_range(3, 0));
                repeat (gap) @(posedge clock);
                #1 busAddrOk[b] = 1'b1;
                if (busWr[b]) begin
                    mem[a] = busWdata[b];
                end
                @(posedge clock);
                #1 busAddrOk[b] = 1'b0;
                gap = int'($urandom_range(3, 0));
                repeat (gap) @(posedge clock);
                #1 busRdata[b] = readWord(a);
                busDataOk[b] = 1'b1;
                @(posedge clock);
                #1 busDataOk[b] = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus file and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic loadStimulus(output bit ok);
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        ok = 1'b0;
        fd = $fopen("test/mipsCoreStimulus.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%c %h %h %h %h", tag, f1, f2, f3, f4);
            if (tag == "I" || tag == "D") begin
                mem[f1] = f2;
            end else if (tag == "W" && n == 5) begin
                wTest.push_back(int'(f1));
                wPc.push_back(f2);
                wReg.push_back(f3);
                wData.push_back(f4);
            end else if (tag == "M") begin
                mAddr.push_back(f1);
                mData.push_back(f2);
            end
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    // sampled at the falling edge, where the trace is stable
    task automatic waitWriteback(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < waitLimit) begin
            @(negedge clock);
            if (debugWbRfWen != 4'h0) begin
                seen = 1'b1;
            end
            cycles++;
        end
    endtask

    task automatic checkValue(input int t, input string name, input word_t exp,
                              input word_t got);
        if (got !== exp) begin
            $display("[FAIL] test %0d %s: expected %h, got %h", t, name, exp, got);
            errors++;
            testErrors++;
        end
    endtask

    task automatic reportTest(input int t);
        if (testErrors == 0) begin
            $display("test %0d: passed", t);
            testsPassed++;
        end else begin
            $display("test %0d: failed with %0d errors", t, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    initial begin
        bit ok;
        bit aborted;
        int dummy;
        rstN    = 1'b0;
        aborted = 1'b0;
        errors  = 0;
        testErrors  = 0;
        testsPassed = 0;
        testsFailed = 0;
        traceCount  = 0;
        for (int b = 0; b < 2; b++) begin
            busAddrOk[b] = 1'b0;
            busDataOk[b] = 1'b0;
            busRdata[b]  = '0;
        end
        dummy = int'($urandom(32'h2e5f));
        loadStimulus(ok);
        if (!ok) begin
            $display("could not open the stimulus file");
            aborted = 1'b1;
        end
        fork
            serveBus(0);
            serveBus(1);
        join_none
        repeat (3) @(posedge clock);
        #1 rstN = 1'b1;

        for (int i = 0; i < wPc.size() && !aborted; i++) begin
            waitWriteback(ok);
            if (!ok) begin
                $display("timeout waiting for write-back of pc %h in test %0d",
                         wPc[i], wTest[i]);
                errors++;
                aborted = 1'b1;
            end else begin
                traceCount++;
                checkValue(wTest[i], "debugWbRfWen", 32'h0000000f, word_t'(debugWbRfWen));
                checkValue(wTest[i], "debugWbPc", wPc[i], debugWbPc);
                checkValue(wTest[i], "debugWbRfWnum", wReg[i], word_t'(debugWbRfWnum));
                checkValue(wTest[i], "debugWbRfWdata", wData[i], debugWbRfWdata);
                if (i == wPc.size() - 1 || wTest[i + 1] != wTest[i]) begin
                    reportTest(wTest[i]);
                end
            end
        end

        // program ends in a jump loop, nothing more may be traced
        if (!aborted) begin
            for (int c = 0; c < quietCycles; c++) begin
                @(negedge clock);
                if (debugWbRfWen != 4'h0) begin
                    $display("unexpected write-back after the last expected one, pc %h",
                             debugWbPc);
                    errors++;
                end
            end
            for (int i = 0; i < mAddr.size(); i++) begin
                checkValue(0, $sformatf("mem[%h]", mAddr[i]), mData[i], readWord(mAddr[i]));
            end
        end

        $display("tests passed %0d, failed %0d, write-backs %0d, errors %0d",
                 testsPassed, testsFailed, traceCount, errors);
        if (errors == 0 && !aborted) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: test/mipsCoreStimulus.txt
# I addr word | D addr word | W test pc reg data | M addr word
# test 1: register ops
I 00000000 24011234
I 00000004 2402fffb
I 00000008 00221821
I 0000000c 00222023
I 00000010 00222824
I 00000014 00223025
I 00000018 00223826
I 0000001c 00224027
I 00000020 0041482a
I 00000024 0041502b
I 00000028 00210021
# test 2: immediates and shifts
I 0000002c 284bfffc
I 00000030 304c80f0
I 00000034 342d8000
I 00000038 384effff
I 0000003c 3c0f8765
I 00000040 00018100
I 00000044 000f8a02
I 00000048 000f9203
# test 3: lw and sw
I 0000004c 24130100
I 00000050 8e740000
I 00000054 ae610004
I 00000058 8e750004
I 0000005c ae740008
# test 4: beq and bne
I 00000060 10220002
I 00000064 24160001
I 00000068 24170002
I 0000006c 14220002
I 00000070 24180003
I 00000074 24190077
I 00000078 10210002
I 0000007c 241a0004
I 00000080 24190088
I 00000084 14210002
I 00000088 241b0005
I 0000008c 241c0006
# test 5: jal, jr and j, then a jump loop
I 00000090 0c000030
I 00000094 241d0007
I 00000098 08000029
I 0000009c 241a000a
I 000000a0 241b00bb
I 000000a4 08000029
I 000000a8 00000000
I 000000c0 241e0008
I 000000c4 03e00008
I 000000c8 24190009
D 00000100 cafef00d
W 1 00000000 01 00001234
W 1 00000004 02 fffffffb
W 1 00000008 03 0000122f
W 1 0000000c 04 00001239
W 1 00000010 05 00001230
W 1 00000014 06 ffffffff
W 1 00000018 07 ffffedcf
W 1 0000001c 08 00000000
W 1 00000020 09 00000001
W 1 00000024 0a 00000000
W 2 0000002c 0b 00000001
W 2 00000030 0c 000080f0
W 2 00000034 0d 00009234
W 2 00000038 0e ffff0004
W 2 0000003c 0f 87650000
W 2 00000040 10 00012340
W 2 00000044 11 00876500
W 2 00000048 12 ff876500
W 3 0000004c 13 00000100
W 3 00000050 14 cafef00d
W 3 00000058 15 00001234
W 4 00000064 16 00000001
W 4 00000068 17 00000002
W 4 00000070 18 00000003
W 4 0000007c 1a 00000004
W 4 00000088 1b 00000005
W 4 0000008c 1c 00000006
W 5 00000090 1f 00000098
W 5 00000094 1d 00000007
W 5 000000c0 1e 00000008
W 5 000000c8 19 00000009
W 5 0000009c 1a 0000000a
M 00000100 cafef00d
M 00000104 00001234
M 00000108 cafef00d

// File: mipsCore.f
common/mipsPkg.sv
common/memReqIf.sv
core/controlUnit.sv
core/alu.sv
core/regFile.sv
core/instrSequencer.sv
rtl/sramMaster.sv
rtl/mipsCore.sv
test/clockGen.sv
test/mipsCoreSva.sv
test/tbMipsCore.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbMipsCore
FILELIST = mipsCore.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
